//--- flist.f
common/mips_pkg.sv
core/control.sv
core/regfile.sv
core/alu.sv
core/cpu_core.sv
hw/cpu_top.sv
test/tb_mem.sv
test/tb_cpu.sv

//--- Makefile
TOP = tb_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

//--- test/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

  localparam logic [31:0] loop_adr = 32'h0000_00ac;  // Word 43, j to itself.
  localparam int          n_stores = 17;

  // Address in the upper half, data in the lower half.
  localparam logic [63:0] exp_store [0:16] = '{
    64'h0000_0180_0000_0001,  // add 5 + -4.
    64'h0000_0184_ffff_fff7,  // sub -4 - 5.
    64'h0000_0188_0000_0004,
    64'h0000_018c_ffff_fffd,
    64'h0000_0190_ffff_fff9,
    64'h0000_0194_0000_0001,  // slt -4 < 5.
    64'h0000_0198_0000_0000,
    64'h0000_019c_0000_0001,  // slti -4 < -1.
    64'h0000_01a0_0000_ff0c,  // andi zero extends.
    64'h0000_01a4_0000_8005,
    64'h0000_01a8_ffff_0003,
    64'h0000_01ac_abcd_0000,  // lui.
    64'h0000_01b0_1234_5679,  // Loaded word plus one.
    64'h0000_01b4_0000_0005,  // beq not taken.
    64'h0000_01b8_ffff_fffc,  // bne not taken.
    64'h0000_01c0_abcd_0000,  // Inside the call.
    64'h0000_01c4_0000_00a8   // Link value after jr.
  };

  logic        clk;
  logic        reset;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_w;

  logic        done;
  logic        started;
  logic        in_req;
  logic        held_we;
  logic [31:0] held_adr;
  logic [31:0] held_dat;
  int          hold_cycles;

  cpu_top UUT (
    .clk(clk), .reset(reset), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .wb_cyc(wb_cyc),
    .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w)
  );

  tb_mem u_mem (
    .clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ==============================
  // Bus monitor
  // ==============================
  always @(negedge clk) begin
    if (reset) begin
      assert (!wb_cyc && !wb_stb && !wb_we) else abort_run("bus active during reset");
      started = 1'b0;
      in_req  = 1'b0;
    end else begin
      assert (wb_cyc || !wb_stb) else abort_run("wb_stb high without wb_cyc");
      if (!started) begin
        assert (wb_stb && !wb_we) else abort_run("no read request right after reset");
        assert (wb_adr == mips_pkg::reset_vector) else abort_run($sformatf(
          "error wb_adr got %h expected %h", wb_adr, mips_pkg::reset_vector));
        started = 1'b1;
      end
      if (wb_stb && in_req) begin
        hold_cycles++;
        assert (wb_adr === held_adr) else abort_run($sformatf(
          "error wb_adr got %h expected %h", wb_adr, held_adr));
        assert (wb_we === held_we) else abort_run($sformatf(
          "error wb_we got %h expected %h", wb_we, held_we));
        assert (wb_dat_w === held_dat) else abort_run($sformatf(
          "error wb_dat_w got %h expected %h", wb_dat_w, held_dat));
        assert (hold_cycles < 16) else abort_run("request never acknowledged");
      end else if (wb_stb) begin
        assert (wb_adr[1:0] == 2'b00) else abort_run($sformatf(
          "error wb_adr got %h expected %h", wb_adr, {wb_adr[31:2], 2'b00}));
        held_adr    = wb_adr;
        held_we     = wb_we;
        held_dat    = wb_dat_w;
        hold_cycles = 0;
      end
      in_req = wb_stb;
    end
  end

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    reset <= 1'b1;
    done = 1'b0;
    repeat (5) @(negedge clk);
    reset <= 1'b0;
    for (int n = 0; n < 4000 && !done; n++) begin
      @(negedge clk);
      done = wb_stb && !wb_we && (wb_adr == loop_adr);
    end
    assert (done) else abort_run("timeout waiting for the self-loop fetch");
    for (int k = 0; k < n_stores; k++) begin
      assert (u_mem.log_adr[k] == exp_store[k][63:32]) else abort_run($sformatf(
        "error store %0d adr got %h expected %h", k, u_mem.log_adr[k], exp_store[k][63:32]));
      assert (u_mem.log_dat[k] == exp_store[k][31:0]) else abort_run($sformatf(
        "error store %0d dat got %h expected %h", k, u_mem.log_dat[k], exp_store[k][31:0]));
    end
    assert (u_mem.log_count == n_stores) else abort_run($sformatf(
      "error store count got %h expected %h", u_mem.log_count, n_stores));
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem (
  input  logic        clk,
  input  logic        reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [31:0] wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack
);

  logic [31:0] words [0:127];
  logic [31:0] log_adr [0:31];
  logic [31:0] log_dat [0:31];
  int          log_count;
  logic [31:0] lfsr;
  logic [1:0]  waits;
  logic        busy;

  function automatic logic [31:0] rtype(input logic [4:0] rd, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [5:0] fn);
    return {mips_pkg::op_rtype, rs, rt, rd, 5'd0, fn};
  endfunction

  // Also used for j and jal, the word index fits in the immediate.
  function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rt,
                                        input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // ==============================
  // Program and data
  // ==============================
  initial begin
    wb_ack    <= 1'b0;
    wb_dat_r  <= 32'd0;
    lfsr      = 32'hcab0;
    busy      = 1'b0;
    waits     = 2'd0;
    log_count = 0;
    for (int i = 0; i < 128; i++) begin
      words[i] = 32'hbad0_0000 ^ (i << 2);
    end
    words[0]  = itype(mips_pkg::op_addi, 5'd1, 5'd0, 16'h0005);
    words[1]  = itype(mips_pkg::op_addi, 5'd2, 5'd0, 16'hfffc);   // r2 = -4.
    words[2]  = itype(mips_pkg::op_ori, 5'd20, 5'd0, 16'h0180);   // Store base.
    words[3]  = rtype(5'd3, 5'd1, 5'd2, mips_pkg::fn_add);
    words[4]  = rtype(5'd4, 5'd2, 5'd1, mips_pkg::fn_sub);
    words[5]  = rtype(5'd5, 5'd1, 5'd2, mips_pkg::fn_and);
    words[6]  = rtype(5'd6, 5'd1, 5'd2, mips_pkg::fn_or);
    words[7]  = rtype(5'd7, 5'd1, 5'd2, mips_pkg::fn_xor);
    words[8]  = rtype(5'd8, 5'd2, 5'd1, mips_pkg::fn_slt);
    words[9]  = rtype(5'd9, 5'd1, 5'd2, mips_pkg::fn_slt);
    words[10] = itype(mips_pkg::op_slti, 5'd10, 5'd2, 16'hffff);
    words[11] = itype(mips_pkg::op_andi, 5'd11, 5'd2, 16'hff0f);
    words[12] = itype(mips_pkg::op_ori, 5'd12, 5'd1, 16'h8000);
    words[13] = itype(mips_pkg::op_xori, 5'd13, 5'd2, 16'hffff);
    words[14] = itype(mips_pkg::op_lui, 5'd14, 5'd0, 16'habcd);
    words[15] = itype(mips_pkg::op_addi, 5'd0, 5'd1, 16'h0007);   // Must not stick.
    for (int k = 0; k < 12; k++) begin
      words[16 + k] = itype(mips_pkg::op_sw, 5'(k + 3), 5'd20, 16'(4 * k));
    end
    words[28] = itype(mips_pkg::op_lw, 5'd15, 5'd0, 16'h0100);    // Base r0 must be zero.
    words[29] = itype(mips_pkg::op_addi, 5'd16, 5'd15, 16'h0001);
    words[30] = itype(mips_pkg::op_sw, 5'd16, 5'd20, 16'd48);
    words[31] = itype(mips_pkg::op_beq, 5'd2, 5'd1, 16'd1);       // Not taken.
    words[32] = itype(mips_pkg::op_sw, 5'd1, 5'd20, 16'd52);
    words[33] = itype(mips_pkg::op_beq, 5'd1, 5'd1, 16'd1);       // Taken.
    words[34] = itype(mips_pkg::op_sw, 5'd0, 5'd20, 16'd60);      // Poison.
    words[35] = itype(mips_pkg::op_bne, 5'd1, 5'd1, 16'd1);       // Not taken.
    words[36] = itype(mips_pkg::op_sw, 5'd2, 5'd20, 16'd56);
    words[37] = itype(mips_pkg::op_bne, 5'd2, 5'd1, 16'd1);       // Taken.
    words[38] = itype(mips_pkg::op_sw, 5'd0, 5'd20, 16'd60);
    words[39] = itype(mips_pkg::op_j, 5'd0, 5'd0, 16'd41);
    words[40] = itype(mips_pkg::op_sw, 5'd0, 5'd20, 16'd60);
    words[41] = itype(mips_pkg::op_jal, 5'd0, 5'd0, 16'd44);
    words[42] = itype(mips_pkg::op_sw, 5'd31, 5'd20, 16'd68);     // After return.
    words[43] = itype(mips_pkg::op_j, 5'd0, 5'd0, 16'd43);        // Self loop.
    words[44] = itype(mips_pkg::op_sw, 5'd14, 5'd20, 16'd64);     // Subroutine.
    words[45] = rtype(5'd0, 5'd31, 5'd0, mips_pkg::fn_jr);
    words[64] = 32'h1234_5678;
  end

  // ==============================
  // Wishbone slave
  // ==============================
  always @(negedge clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
      busy = 1'b0;
    end else if (wb_ack) begin
      wb_ack <= 1'b0;  // One ack per request.
      busy = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!busy) begin
        busy = 1'b1;
        lfsr = lfsr_next(lfsr);
        waits[0] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        waits[1] = lfsr[0];
      end
      if (waits == 2'd0) begin
        wb_ack <= 1'b1;
        if (wb_we) begin
          words[wb_adr[8:2]] = wb_dat_w;
          if (log_count < 32) begin
            log_adr[log_count] = wb_adr;
            log_dat[log_count] = wb_dat_w;
          end
          log_count++;
        end else begin
          wb_dat_r <= words[wb_adr[8:2]];
        end
      end else begin
        waits = waits - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] wb_dat_r,
  input  logic        wb_ack,
  output logic        wb_cyc,
  output logic        wb_stb,
  output logic        wb_we,
  output logic [31:0] wb_adr,
  output logic [31:0] wb_dat_w
);

  // Single Wishbone master port for both fetch and data.
  cpu_core u_core (
    .clk      (clk),
    .reset    (reset),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w)
  );

endmodule

`default_nettype wire

//--- core/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] wb_dat_r,
  input  logic        wb_ack,
  output logic        wb_cyc,
  output logic        wb_stb,
  output logic        wb_we,
  output logic [31:0] wb_adr,
  output logic [31:0] wb_dat_w
);

  logic [1:0]       state;
  logic [31:0]      pc;
  mips_pkg::instr_t ir;

  logic        rd_select, imdt_sel, branch, branch_ne, jump1, jump2;
  logic [1:0]  alu_op;
  logic        alu_src, data_read, data_write, write_enable, link;
  logic [31:0] rs_data, rt_data;
  logic [31:0] imm_ext, alu_b, alu_result;
  logic        alu_zero;
  logic [31:0] pc_plus4, branch_target, jump_target, next_pc;
  logic        branch_taken;
  logic        wr_en;
  logic [4:0]  wr_addr;
  logic [31:0] wr_data;

  control u_control (
    .opcode(ir.r.opcode), .function_code(ir.r.funct),
    .rd_select(rd_select), .imdt_sel(imdt_sel), .branch(branch), .branch_ne(branch_ne),
    .jump1(jump1), .jump2(jump2), .alu_op(alu_op), .alu_src(alu_src),
    .data_read(data_read), .data_write(data_write), .write_enable(write_enable),
    .link(link)
  );

  regfile u_regfile (
    .clk(clk), .write_enable(wr_en), .rs_addr(ir.r.rs), .rt_addr(ir.r.rt),
    .rd_addr(wr_addr), .rd_data(wr_data), .rs_data(rs_data), .rt_data(rt_data)
  );

  alu u_alu (
    .alu_op(alu_op), .opcode(ir.r.opcode), .function_code(ir.r.funct),
    .a(rs_data), .b(alu_b), .result(alu_result), .zero(alu_zero)
  );

  // ==============================
  // Datapath
  // ==============================
  assign imm_ext = imdt_sel ? {16'h0000, ir.i.imm} : {{16{ir.i.imm[15]}}, ir.i.imm};
  assign alu_b   = alu_src ? imm_ext : rt_data;

  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
  assign jump_target   = {pc_plus4[31:28], ir[25:0], 2'b00};
  assign branch_taken  = branch && (alu_zero != branch_ne);

  always_comb begin
    if (jump2)             next_pc = rs_data;
    else if (jump1)        next_pc = jump_target;
    else if (branch_taken) next_pc = branch_target;
    else                   next_pc = pc_plus4;
  end

  // lw writes on the data ack, everything else during execute.
  assign wr_en = ((state == mips_pkg::st_execute) && write_enable && !data_read) ||
                 ((state == mips_pkg::st_memory) && data_read && wb_ack);
  assign wr_addr = link ? mips_pkg::reg_link : (rd_select ? ir.r.rd : ir.r.rt);
  assign wr_data = link ? pc_plus4 : (data_read ? wb_dat_r : alu_result);

  // ==============================
  // Sequencer and bus master
  // ==============================
  assign wb_stb = wb_cyc;

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= mips_pkg::st_fetch;
      pc     <= mips_pkg::reset_vector;
      wb_cyc <= 1'b0;
      wb_we  <= 1'b0;
    end else begin
      case (state)
        mips_pkg::st_fetch: begin
          if (!wb_cyc) begin
            wb_cyc <= 1'b1;  // Instruction read.
            wb_we  <= 1'b0;
          end else if (wb_ack) begin
            wb_cyc <= 1'b0;
            state  <= mips_pkg::st_execute;
          end
        end
        mips_pkg::st_execute: begin
          if (data_read || data_write) begin
            wb_cyc <= 1'b1;
            wb_we  <= data_write;
            state  <= mips_pkg::st_memory;
          end else begin
            pc    <= next_pc;
            state <= mips_pkg::st_fetch;
          end
        end
        mips_pkg::st_memory: begin
          if (wb_ack) begin
            wb_cyc <= 1'b0;
            wb_we  <= 1'b0;
            pc     <= pc_plus4;
            state  <= mips_pkg::st_fetch;
          end
        end
        default: state <= mips_pkg::st_fetch;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == mips_pkg::st_fetch) && !wb_cyc) begin
      wb_adr <= pc;
    end
    if ((state == mips_pkg::st_fetch) && wb_cyc && wb_ack) begin
      ir <= wb_dat_r;
    end
    if (state == mips_pkg::st_execute) begin
      wb_adr   <= alu_result;  // Effective address for lw and sw.
      wb_dat_w <= rt_data;
    end
  end

endmodule

`default_nettype wire

//--- core/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic [1:0]  alu_op,
  input  logic [5:0]  opcode,
  input  logic [5:0]  function_code,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] result,
  output logic        zero
);

  logic [31:0] less;

  assign less = {31'd0, $signed(a) < $signed(b)};

  always_comb begin
    case (alu_op)
      mips_pkg::alu_op_add: result = a + b;
      mips_pkg::alu_op_sub: result = a - b;
      mips_pkg::alu_op_funct: begin
        case (function_code)
          mips_pkg::fn_add: result = a + b;
          mips_pkg::fn_sub: result = a - b;
          mips_pkg::fn_and: result = a & b;
          mips_pkg::fn_or:  result = a | b;
          mips_pkg::fn_xor: result = a ^ b;
          mips_pkg::fn_slt: result = less;
          default:          result = 32'd0;  // jr and unused functs.
        endcase
      end
      default: begin
        case (opcode)
          mips_pkg::op_addi: result = a + b;
          mips_pkg::op_slti: result = less;
          mips_pkg::op_andi: result = a & b;
          mips_pkg::op_ori:  result = a | b;
          mips_pkg::op_xori: result = a ^ b;
          mips_pkg::op_lui:  result = {b[15:0], 16'h0000};
          default:           result = 32'd0;
        endcase
      end
    endcase
  end

  assign zero = (result == 32'd0);  // Drives the branch decision.

endmodule

`default_nettype wire

//--- core/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  logic        clk,
  input  logic        write_enable,
  input  logic [4:0]  rs_addr,
  input  logic [4:0]  rt_addr,
  input  logic [4:0]  rd_addr,
  input  logic [31:0] rd_data,
  output logic [31:0] rs_data,
  output logic [31:0] rt_data
);

  logic [31:0] regs [0:31];

  always_ff @(posedge clk) begin
    if (write_enable && (rd_addr != 5'd0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // Register zero always reads as zero.
  assign rs_data = (rs_addr == 5'd0) ? 32'd0 : regs[rs_addr];
  assign rt_data = (rt_addr == 5'd0) ? 32'd0 : regs[rt_addr];

endmodule

`default_nettype wire

//--- core/control.sv
`timescale 1ns/1ps
`default_nettype none

module control (
  input  logic [5:0] opcode,
  input  logic [5:0] function_code,
  output logic       rd_select,
  output logic       imdt_sel,
  output logic       branch,
  output logic       branch_ne,
  output logic       jump1,
  output logic       jump2,
  output logic [1:0] alu_op,
  output logic       alu_src,
  output logic       data_read,
  output logic       data_write,
  output logic       write_enable,
  output logic       link
);

  logic is_rtype;

  assign is_rtype = (opcode == mips_pkg::op_rtype);

  always_comb begin
    rd_select = is_rtype;  // R-type writes rd, others rt.

    case (opcode)
      mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori: imdt_sel = 1'b1;
      default: imdt_sel = 1'b0;
    endcase

    case (opcode)
      mips_pkg::op_beq, mips_pkg::op_bne: branch = 1'b1;
      default: branch = 1'b0;
    endcase
    branch_ne = (opcode == mips_pkg::op_bne);

    case (opcode)
      mips_pkg::op_j, mips_pkg::op_jal: jump1 = 1'b1;
      default: jump1 = 1'b0;
    endcase
    jump2 = is_rtype && (function_code == mips_pkg::fn_jr);

    case (opcode)
      mips_pkg::op_rtype, mips_pkg::op_beq, mips_pkg::op_bne: alu_src = 1'b0;
      default: alu_src = 1'b1;
    endcase

    case (opcode)
      mips_pkg::op_rtype: alu_op = mips_pkg::alu_op_funct;
      mips_pkg::op_beq, mips_pkg::op_bne: alu_op = mips_pkg::alu_op_sub;
      mips_pkg::op_addi, mips_pkg::op_slti, mips_pkg::op_andi,
      mips_pkg::op_ori, mips_pkg::op_xori, mips_pkg::op_lui: alu_op = mips_pkg::alu_op_imm;
      default: alu_op = mips_pkg::alu_op_add;
    endcase

    data_read  = (opcode == mips_pkg::op_lw);
    data_write = (opcode == mips_pkg::op_sw);
    link       = (opcode == mips_pkg::op_jal);

    case (opcode)
      mips_pkg::op_rtype: write_enable = !jump2;  // jr has no destination.
      mips_pkg::op_addi, mips_pkg::op_slti, mips_pkg::op_andi, mips_pkg::op_ori,
      mips_pkg::op_xori, mips_pkg::op_lui, mips_pkg::op_lw, mips_pkg::op_jal: begin
        write_enable = 1'b1;
      end
      default: write_enable = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- common/mips_pkg.sv
`default_nettype none

package mips_pkg;

  // ==============================
  // Opcodes
  // ==============================
  localparam logic [5:0] op_rtype = 6'd0;
  localparam logic [5:0] op_j     = 6'd2;
  localparam logic [5:0] op_jal   = 6'd3;
  localparam logic [5:0] op_beq   = 6'd4;
  localparam logic [5:0] op_bne   = 6'd5;
  localparam logic [5:0] op_addi  = 6'd8;
  localparam logic [5:0] op_slti  = 6'd10;
  localparam logic [5:0] op_andi  = 6'd12;
  localparam logic [5:0] op_ori   = 6'd13;
  localparam logic [5:0] op_xori  = 6'd14;
  localparam logic [5:0] op_lui   = 6'd15;
  localparam logic [5:0] op_lw    = 6'd35;
  localparam logic [5:0] op_sw    = 6'd43;

  // ==============================
  // R-type funct codes
  // ==============================
  localparam logic [5:0] fn_jr  = 6'd8;
  localparam logic [5:0] fn_add = 6'd32;
  localparam logic [5:0] fn_sub = 6'd34;
  localparam logic [5:0] fn_and = 6'd36;
  localparam logic [5:0] fn_or  = 6'd37;
  localparam logic [5:0] fn_xor = 6'd38;
  localparam logic [5:0] fn_slt = 6'd42;

  // ALU class passed from control to the ALU.
  localparam logic [1:0] alu_op_add   = 2'd0;  // Address calculation.
  localparam logic [1:0] alu_op_sub   = 2'd1;  // Branch compare.
  localparam logic [1:0] alu_op_funct = 2'd2;
  localparam logic [1:0] alu_op_imm   = 2'd3;

  // Core sequencer states.
  localparam logic [1:0] st_fetch   = 2'd0;
  localparam logic [1:0] st_execute = 2'd1;
  localparam logic [1:0] st_memory  = 2'd2;

  localparam logic [31:0] reset_vector = 32'h0000_0000;
  localparam logic [4:0]  reg_link     = 5'd31;  // jal destination.

  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } r;
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
    } i;
  } instr_t;

endpackage

`default_nettype wire
